//--- files.f
rtl/msx_cart_pkg.sv
rtl/fmpac_regs.sv
rtl/fmpac_decode.sv
rtl/opll_write_port.sv
rtl/fmpac_cart_top.sv
tests/tb_fmpac_cart.sv

//--- tests/tb_fmpac_cart.sv
module tb_fmpac_cart;

    localparam logic [31:0] SEED = 32'h8dfb1fc0;
    localparam int BANK_ROUNDS = 4;
    localparam int SRAM_OPS    = 6;
    localparam int OPLL_ROUNDS = 4;
    localparam int WRONG_OPS   = 4;
    // Accesses per phase, in the order the stimulus runs them
    localparam int N_ACCESS = 8 + BANK_ROUNDS * 6 + (6 + SRAM_OPS) + 8
                              + (3 + OPLL_ROUNDS * 2) + (5 + WRONG_OPS + 5);

    logic                      cpu_bus;
    logic                      arst_n;
    msx_cart_pkg::cpu_req_t    req;
    msx_cart_pkg::block_info_t blk;
    msx_cart_pkg::map_out_t    mem;
    msx_cart_pkg::opll_wr_t    opll;

    // Reference model, one copy per instance
    logic [7:0]  m_enable [2];
    logic [1:0]  m_bank   [2];
    logic [15:0] m_magic  [2];
    logic        m_we;
    logic [7:0]  m_reg;
    logic [7:0]  m_data;

    msx_cart_pkg::map_out_t exp_mem;
    msx_cart_pkg::opll_wr_t exp_opll;
    logic [13:0] ofs;
    logic        sel;
    logic        unl;
    int          n_issued  = 0;
    int          n_data_wr = 0;
    int          n_we      = 0;

    fmpac_cart_top i_dut (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .req     (req),
        .blk     (blk),
        .mem     (mem),
        .opll    (opll)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #2 cpu_bus = ~cpu_bus;
    end

    assign ofs = req.addr.fields.offset;
    assign sel = (blk.typ == msx_cart_pkg::MAPPER_FMPAC) && req.mreq;
    assign unl = (m_magic[blk.id] == 16'h694D);

    // Register rules, updated on the same edge as the DUT
    always @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2; i++) begin
                m_enable[i] <= 8'h00;
                m_bank[i]   <= 2'b00;
                m_magic[i]  <= 16'h0000;
            end
            m_we   <= 1'b0;
            m_reg  <= 8'h00;
            m_data <= 8'h00;
        end else begin
            m_we <= 1'b0;
            if (req.req && sel && req.wr) begin
                case (ofs)
                    14'h1FFE: begin
                        if (!m_enable[blk.id][4]) begin
                            m_magic[blk.id][7:0] <= req.data;
                        end
                    end
                    14'h1FFF: begin
                        if (!m_enable[blk.id][4]) begin
                            m_magic[blk.id][15:8] <= req.data;
                        end
                    end
                    14'h3FF6: begin
                        m_enable[blk.id] <= req.data & 8'h11;
                        // Lock bit wipes the key
                        if (req.data[4]) begin
                            m_magic[blk.id] <= 16'h0000;
                        end
                    end
                    14'h3FF7: m_bank[blk.id] <= req.data[1:0];
                    14'h3FF4: m_reg <= req.data;
                    14'h3FF5: begin
                        m_we   <= 1'b1;
                        m_data <= req.data;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Expected outputs for the access on the bus right now
    always_comb begin
        exp_mem.sram_cs = sel && unl && (ofs < 14'h1FFE) && (req.rd || req.wr);
        exp_mem.ram_cs  = sel && !exp_mem.sram_cs && req.rd && (req.addr.fields.page == 2'd1);
        exp_mem.rnw     = !(exp_mem.sram_cs && req.wr);
        if (!sel) begin
            exp_mem.addr = {27{1'b1}};
        end else if (exp_mem.sram_cs) begin
            exp_mem.addr = 27'(ofs[12:0]);
        end else begin
            exp_mem.addr = 27'(m_bank[blk.id]) * 27'h4000 + 27'(ofs);
        end
        exp_mem.data = 8'hFF;
        if (blk.typ == msx_cart_pkg::MAPPER_FMPAC) begin
            case (ofs)
                14'h3FF6: exp_mem.data = m_enable[blk.id];
                14'h3FF7: exp_mem.data = {6'b0, m_bank[blk.id]};
                14'h1FFE: exp_mem.data = unl ? m_magic[blk.id][7:0] : 8'hFF;
                14'h1FFF: exp_mem.data = unl ? m_magic[blk.id][15:8] : 8'hFF;
                default: ;
            endcase
        end
        exp_opll = '{we: m_we, en: sel && m_enable[blk.id][0], reg_addr: m_reg, data: m_data};
    end

    always @(posedge cpu_bus) begin
        if (arst_n && opll.we) begin
            n_we <= n_we + 1;
        end
    end

    a_selects: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        {mem.sram_cs, mem.ram_cs, mem.rnw} == {exp_mem.sram_cs, exp_mem.ram_cs, exp_mem.rnw})
        else fail_value("mem.{sram_cs,ram_cs,rnw}",
                        $sampled({exp_mem.sram_cs, exp_mem.ram_cs, exp_mem.rnw}),
                        $sampled({mem.sram_cs, mem.ram_cs, mem.rnw}));
    a_addr: assert property (@(posedge cpu_bus) disable iff (!arst_n) mem.addr == exp_mem.addr)
        else fail_value("mem.addr", $sampled(exp_mem.addr), $sampled(mem.addr));
    a_rdata: assert property (@(posedge cpu_bus) disable iff (!arst_n) mem.data == exp_mem.data)
        else fail_value("mem.data", $sampled(exp_mem.data), $sampled(mem.data));
    a_opll: assert property (@(posedge cpu_bus) disable iff (!arst_n) opll == exp_opll)
        else fail_value("opll", $sampled(exp_opll), $sampled(opll));

    task automatic finish_failed();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [39:0] exp, input logic [39:0] got);
        $display("MISMATCH time=%0t %s expected=%0h got=%0h", $time, name, exp, got);
        finish_failed();
    endtask

    task automatic fail_text(input string what);
        $display("ERROR: %s", what);
        finish_failed();
    endtask

    // One strobe cycle, then one idle cycle
    task automatic access(input logic id, input logic [2:0] typ, input logic rd,
                          input logic wr, input logic [15:0] addr, input logic [7:0] data);
        @(negedge cpu_bus);
        blk = '{typ: typ, id: id};
        req = '{req: 1'b1, mreq: 1'b1, rd: rd, wr: wr, addr: addr, data: data};
        n_issued++;
        if (wr && typ == msx_cart_pkg::MAPPER_FMPAC && addr[13:0] == 14'h3FF5) begin
            n_data_wr++;
        end
        @(negedge cpu_bus);
        req.req  = 1'b0;
        req.mreq = 1'b0;
        req.rd   = 1'b0;
        req.wr   = 1'b0;
    endtask

    task automatic read_at(input logic id, input logic [15:0] addr);
        access(id, msx_cart_pkg::MAPPER_FMPAC, 1'b1, 1'b0, addr, 8'h00);
    endtask

    task automatic write_at(input logic id, input logic [15:0] addr, input logic [7:0] data);
        access(id, msx_cart_pkg::MAPPER_FMPAC, 1'b0, 1'b1, addr, data);
    endtask

    // Register offsets decode on any page
    function automatic logic [15:0] any_page(input logic [13:0] o);
        logic [1:0] pg;
        pg = 2'($urandom);
        return {pg, o};
    endfunction

    function automatic logic [15:0] page1(input logic [13:0] o);
        return {2'd1, o};
    endfunction

    initial begin
        logic        id;
        logic [2:0]  t;
        int          k;
        void'($urandom(SEED));
        req    = '0;
        blk    = '{typ: msx_cart_pkg::MAPPER_FMPAC, id: 1'b0};
        arst_n = 1'b0;
        repeat (5) @(posedge cpu_bus);
        @(negedge cpu_bus);
        arst_n = 1'b1;

        // Reset values, bank 0 maps page 1 straight to the offset
        for (int i = 0; i < 2; i++) begin
            read_at(i[0], any_page(14'h3FF6));
            read_at(i[0], any_page(14'h3FF7));
        end
        repeat (4) read_at(1'b0, page1(14'($urandom)));

        // Bank switching, other instance must keep its mapping
        repeat (BANK_ROUNDS) begin
            id = 1'($urandom);
            write_at(id, any_page(14'h3FF7), 8'($urandom));
            repeat (3) read_at(id, page1(14'($urandom)));
            repeat (2) read_at(!id, page1(14'($urandom)));
        end

        // Key bytes open SRAM on instance 0 only
        write_at(1'b0, any_page(14'h1FFE), 8'h4D);
        write_at(1'b0, any_page(14'h1FFF), 8'h69);
        read_at(1'b0, any_page(14'h1FFE));
        read_at(1'b0, any_page(14'h1FFF));
        repeat (SRAM_OPS) begin
            k = $urandom % 2;
            access(1'b0, msx_cart_pkg::MAPPER_FMPAC, k == 0, k == 1,
                   any_page(14'($urandom % 32'h1FFE)), 8'($urandom));
        end
        read_at(1'b1, any_page(14'h1FFE));
        read_at(1'b1, any_page(14'($urandom % 32'h1FFE)));

        // Lock bit clears the key and blocks new key writes
        write_at(1'b0, any_page(14'h3FF6), 8'($urandom) | 8'h10);
        read_at(1'b0, any_page(14'h3FF6));
        read_at(1'b0, any_page(14'($urandom % 32'h1FFE)));
        write_at(1'b0, any_page(14'($urandom % 32'h1FFE)), 8'($urandom));
        write_at(1'b0, any_page(14'h1FFE), 8'h4D);
        write_at(1'b0, any_page(14'h1FFF), 8'h69);
        read_at(1'b0, any_page(14'h1FFE));
        read_at(1'b0, any_page(14'h1FFF));

        // Sound on, then register number and data pairs
        write_at(1'b0, any_page(14'h3FF6), 8'h01);
        repeat (OPLL_ROUNDS) begin
            write_at(1'b0, any_page(14'h3FF4), 8'($urandom));
            write_at(1'b0, any_page(14'h3FF5), 8'($urandom));
        end
        write_at(1'b0, any_page(14'h3FF6), 8'h00);
        write_at(1'b0, any_page(14'h3FF5), 8'($urandom));

        // Any other mapper type, skipping the FM-PAC code
        t = 3'($urandom % 7);
        if (t >= msx_cart_pkg::MAPPER_FMPAC) begin
            t = t + 3'd1;
        end
        // Low key byte in place, so a stray high byte would open SRAM
        write_at(1'b0, any_page(14'h1FFE), 8'h4D);
        access(1'b0, t, 1'b0, 1'b1, any_page(14'h3FF6), 8'h11);
        access(1'b1, t, 1'b0, 1'b1, any_page(14'h3FF7), {6'b0, ~m_bank[1]});
        access(1'b0, t, 1'b0, 1'b1, any_page(14'h1FFF), 8'h69);
        access(1'b0, t, 1'b0, 1'b1, any_page(14'h3FF5), 8'h5A);
        repeat (WRONG_OPS) begin
            k = $urandom % 2;
            access(1'($urandom), t, k == 0, k == 1, 16'($urandom), 8'($urandom));
        end
        for (int i = 0; i < 2; i++) begin
            read_at(i[0], any_page(14'h3FF6));
            read_at(i[0], any_page(14'h3FF7));
        end
        read_at(1'b0, any_page(14'h1FFE));

        repeat (3) @(negedge cpu_bus);
        if (n_issued != N_ACCESS) begin
            fail_text("number of accesses run differs from the schedule");
        end else if (n_we != n_data_wr) begin
            fail_text("OPLL write strobes seen differ from data writes issued");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

    // Ten cycles per scheduled access is far beyond the two each one needs
    initial begin
        repeat (10 * N_ACCESS) @(posedge cpu_bus);
        fail_text("watchdog expired before the stimulus finished");
    end

endmodule

//--- rtl/fmpac_cart_top.sv
module fmpac_cart_top (
    input  logic                      cpu_bus,
    input  logic                      arst_n,
    input  msx_cart_pkg::cpu_req_t    req,
    input  msx_cart_pkg::block_info_t blk,
    output msx_cart_pkg::map_out_t    mem,
    output msx_cart_pkg::opll_wr_t    opll
);

    // State of the instance picked by blk.id
    msx_cart_pkg::fmpac_state_t cur;

    // Sound enable from the decoder, strobe side from the OPLL port
    logic       opll_en;
    logic       opll_we;
    logic [7:0] opll_reg;
    logic [7:0] opll_data;

    // Enable, bank and key registers
    fmpac_regs i_regs (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .req     (req),
        .blk     (blk),
        .cur     (cur)
    );

    // Chip selects, physical address and read-back
    fmpac_decode i_decode (
        .req     (req),
        .blk     (blk),
        .cur     (cur),
        .mem     (mem),
        .opll_en (opll_en)
    );

    // Registered write strobe toward the FM chip
    opll_write_port i_opll (
        .cpu_bus  (cpu_bus),
        .arst_n   (arst_n),
        .req      (req),
        .blk      (blk),
        .we       (opll_we),
        .reg_addr (opll_reg),
        .data     (opll_data)
    );

    // Enable is combinational, the strobe fields are registered
    assign opll = '{
        we:       opll_we,
        en:       opll_en,
        reg_addr: opll_reg,
        data:     opll_data
    };

endmodule

//--- rtl/opll_write_port.sv
module opll_write_port (
    input  logic                      cpu_bus,
    input  logic                      arst_n,
    input  msx_cart_pkg::cpu_req_t    req,
    input  msx_cart_pkg::block_info_t blk,
    output logic                      we,
    output logic [7:0]                reg_addr,
    output logic [7:0]                data
);

    logic wr_hit;
    logic addr_wr;
    logic data_wr;

    assign wr_hit  = msx_cart_pkg::fmpac_wr(req, blk);
    // Register number select
    assign addr_wr = wr_hit && (req.addr.fields.offset == msx_cart_pkg::OFS_OPLL_ADDR);
    // Data write, fires the chip strobe
    assign data_wr = wr_hit && (req.addr.fields.offset == msx_cart_pkg::OFS_OPLL_DATA);

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            we       <= 1'b0;
            reg_addr <= 8'h00;
            data     <= 8'h00;
        end else begin
            // Strobe lasts one cycle per data write
            we <= data_wr;
            // Register number persists across any number of data writes
            if (addr_wr) begin
                reg_addr <= req.data;
            end
            // Data held until the next data write
            if (data_wr) begin
                data <= req.data;
            end
        end
    end

    // Back-to-back strobes only come from back-to-back data writes
    a_we_pulse: assert property (
        @(posedge cpu_bus) disable iff (!arst_n)
        (we && $past(we)) |-> ($past(data_wr) && $past(data_wr, 2))
    );

endmodule

//--- rtl/fmpac_decode.sv
module fmpac_decode (
    input  msx_cart_pkg::cpu_req_t     req,
    input  msx_cart_pkg::block_info_t  blk,
    input  msx_cart_pkg::fmpac_state_t cur,
    output msx_cart_pkg::map_out_t     mem,
    output logic                       opll_en
);

    logic        is_fmpac;
    logic        sel;
    logic        unlocked;
    logic        sram_hit;
    logic        rom_hit;
    logic [13:0] ofs;
    logic [26:0] sram_addr;
    logic [26:0] rom_addr;
    logic [7:0]  rd_data;

    assign ofs      = req.addr.fields.offset;
    assign is_fmpac = (blk.typ == msx_cart_pkg::MAPPER_FMPAC);
    // Any memory cycle into this slot
    assign sel      = is_fmpac && req.mreq;
    // Correct key opens the 8 KB battery SRAM
    assign unlocked = (cur.magic == msx_cart_pkg::SRAM_MAGIC);

    // SRAM overlays the offsets below the magic registers, on any page
    assign sram_hit = sel && unlocked && (ofs < msx_cart_pkg::OFS_MAGIC_LO)
                      && (req.rd || req.wr);
    // ROM is read-only and only on page 1, SRAM takes priority
    assign rom_hit  = sel && !sram_hit && req.rd
                      && (req.addr.fields.page == msx_cart_pkg::MAPPED_PAGE);

    // 8 KB SRAM uses 13 offset bits
    assign sram_addr = {14'b0, ofs[12:0]};
    // Bank selects the 16 KB slice of the 64 KB ROM
    assign rom_addr  = {11'b0, cur.bank, ofs};

    // Register read-back, FF when nothing answers
    always_comb begin
        rd_data = 8'hFF;
        if (is_fmpac) begin
            case (ofs)
                msx_cart_pkg::OFS_ENABLE: rd_data = cur.enable;
                msx_cart_pkg::OFS_BANK:   rd_data = {6'b0, cur.bank};
                // Key bytes are only visible once they open SRAM
                msx_cart_pkg::OFS_MAGIC_LO: begin
                    if (unlocked) begin
                        rd_data = cur.magic[7:0];
                    end
                end
                msx_cart_pkg::OFS_MAGIC_HI: begin
                    if (unlocked) begin
                        rd_data = cur.magic[15:8];
                    end
                end
                default: ;
            endcase
        end
    end

    assign mem.sram_cs = sram_hit;
    assign mem.ram_cs  = rom_hit;
    // Only SRAM can be written
    assign mem.rnw     = !(sram_hit && req.wr);
    assign mem.addr    = !sel     ? msx_cart_pkg::ADDR_IDLE :
                         sram_hit ? sram_addr : rom_addr;
    assign mem.data    = rd_data;

    // Sound on only while this cartridge is addressed
    assign opll_en = sel && cur.enable[0];

    // One memory chip at a time
    always_comb begin
        a_cs_excl: assert final (!(mem.sram_cs && mem.ram_cs));
    end

endmodule

//--- rtl/fmpac_regs.sv
module fmpac_regs (
    input  logic                       cpu_bus,
    input  logic                       arst_n,
    input  msx_cart_pkg::cpu_req_t     req,
    input  msx_cart_pkg::block_info_t  blk,
    output msx_cart_pkg::fmpac_state_t cur
);

    // Per-instance copies, selected by blk.id
    logic [7:0]  enable [msx_cart_pkg::NUM_INST];
    logic [1:0]  bank   [msx_cart_pkg::NUM_INST];
    logic [15:0] magic  [msx_cart_pkg::NUM_INST];

    logic        wr_hit;
    logic [13:0] ofs;
    logic        locked;

    // Page bits play no part in register decoding
    assign ofs    = req.addr.fields.offset;
    assign wr_hit = msx_cart_pkg::fmpac_wr(req, blk);
    // Bit 4 of enable freezes the magic bytes
    assign locked = enable[blk.id][4];

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < msx_cart_pkg::NUM_INST; i++) begin
                enable[i] <= 8'h00;
                bank[i]   <= 2'b00;
                magic[i]  <= 16'h0000;
            end
        end else if (wr_hit) begin
            case (ofs)
                msx_cart_pkg::OFS_MAGIC_LO: begin
                    // Ignored while the lock bit is set
                    if (!locked) begin
                        magic[blk.id][7:0] <= req.data;
                    end
                end
                msx_cart_pkg::OFS_MAGIC_HI: begin
                    if (!locked) begin
                        magic[blk.id][15:8] <= req.data;
                    end
                end
                msx_cart_pkg::OFS_ENABLE: begin
                    // Unused bits never stored
                    enable[blk.id] <= req.data & msx_cart_pkg::ENABLE_MASK;
                    // Setting the lock also wipes the key, so SRAM closes at once
                    if (req.data[4]) begin
                        magic[blk.id] <= 16'h0000;
                    end
                end
                msx_cart_pkg::OFS_BANK: begin
                    // Four 16 KB banks, upper data bits dropped
                    bank[blk.id] <= req.data[1:0];
                end
                // OPLL offsets are handled by the sound port
                default: ;
            endcase
        end
    end

    // Present the addressed instance to the decoder
    assign cur.enable = enable[blk.id];
    assign cur.bank   = bank[blk.id];
    assign cur.magic  = magic[blk.id];

    for (genvar g = 0; g < msx_cart_pkg::NUM_INST; g++) begin : g_chk
        // No stray enable bits in either instance
        a_enable_masked: assert property (
            @(posedge cpu_bus) disable iff (!arst_n)
            (enable[g] & ~msx_cart_pkg::ENABLE_MASK) == 8'h00
        );
    end

endmodule

//--- rtl/msx_cart_pkg.sv
package msx_cart_pkg;

    // Type code the slot logic gives to an FM-PAC cartridge
    localparam logic [2:0] MAPPER_FMPAC = 3'd3;

    // Only CPU page 1 (4000h-7FFFh) is backed by cartridge ROM
    localparam logic [1:0] MAPPED_PAGE = 2'd1;

    // Register offsets inside the 16 KB window, page bits ignored
    localparam logic [13:0] OFS_MAGIC_LO  = 14'h1FFE;
    localparam logic [13:0] OFS_MAGIC_HI  = 14'h1FFF;
    localparam logic [13:0] OFS_OPLL_ADDR = 14'h3FF4;
    localparam logic [13:0] OFS_OPLL_DATA = 14'h3FF5;
    localparam logic [13:0] OFS_ENABLE    = 14'h3FF6;
    localparam logic [13:0] OFS_BANK      = 14'h3FF7;

    // Two-byte key that opens the battery SRAM
    localparam logic [15:0] SRAM_MAGIC  = 16'h694D;
    // Only bit 0 (sound on) and bit 4 (SRAM lock) exist in the enable register
    localparam logic [7:0]  ENABLE_MASK = 8'h11;
    // Physical address driven when the cartridge is not addressed
    localparam logic [26:0] ADDR_IDLE   = {27{1'b1}};
    // Cartridge instances tracked, indexed by block id
    localparam int          NUM_INST    = 2;

    // CPU address, seen flat or split into 16 KB page and offset
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [1:0]  page;
            logic [13:0] offset;
        } fields;
    } cpu_addr_u;

    typedef struct packed {
        logic       req;
        logic       mreq;
        logic       rd;
        logic       wr;
        cpu_addr_u  addr;
        logic [7:0] data;
    } cpu_req_t;

    typedef struct packed {
        logic [2:0] typ;
        logic       id;
    } block_info_t;

    typedef struct packed {
        logic        sram_cs;
        logic        ram_cs;
        logic        rnw;
        logic [26:0] addr;
        logic [7:0]  data;
    } map_out_t;

    typedef struct packed {
        logic       we;
        logic       en;
        logic [7:0] reg_addr;
        logic [7:0] data;
    } opll_wr_t;

    // State of the addressed instance, as the decoder sees it
    typedef struct packed {
        logic [7:0]  enable;
        logic [1:0]  bank;
        logic [15:0] magic;
    } fmpac_state_t;

    // Qualified register write: strobe, memory cycle, write, and our mapper type
    function automatic logic fmpac_wr(cpu_req_t r, block_info_t b);
        return r.req && r.mreq && r.wr && (b.typ == MAPPER_FMPAC);
    endfunction

endpackage
